// ==== design/l0_cache_pkg.sv ====
/*
 * Shared types of the L0 instruction cache: 32-bit fetch, 128-bit lines, 4 lines.
 * Only uncompressed RV32 instructions are predecoded for prefetching.
 */
package l0_cache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int unsigned FetchAw    = 32;
  localparam int unsigned FetchDw    = 32;
  localparam int unsigned LineWidth  = 128;
  localparam int unsigned LineCount  = 4;
  localparam int unsigned LineAlign  = 4;
  localparam int unsigned FetchAlign = 2;
  localparam int unsigned TagWidth   = FetchAw - LineAlign;
  localparam int unsigned FetchPkts  = LineWidth / FetchDw;
  // word select bits inside a line
  localparam int unsigned WordSel    = LineAlign - FetchAlign;

  // memory request ids
  localparam int unsigned IdWidth = 2;
  localparam logic [IdWidth-1:0] IdRefill   = 2'b01;
  localparam logic [IdWidth-1:0] IdPrefetch = 2'b10;

  // major opcodes seen by the predecoder
  localparam logic [6:0] OpcBranch = 7'b1100011;
  localparam logic [6:0] OpcJal    = 7'b1101111;

  typedef logic [FetchAw-1:0]                fetch_addr_t;
  typedef logic [FetchDw-1:0]                fetch_word_t;
  typedef logic [FetchPkts-1:0][FetchDw-1:0] line_t;
  typedef logic [TagWidth-1:0]               line_tag_t;
  typedef logic [LineCount-1:0]              line_sel_t;

  typedef struct packed {
    fetch_addr_t        addr;
    logic [IdWidth-1:0] id;
  } mem_req_t;

  typedef struct packed {
    line_t              data;
    logic [IdWidth-1:0] id;
  } mem_rsp_t;

  // ----------------------------------------
  // instruction views
  // ----------------------------------------
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    b_type_t b;
    j_type_t j;
  } rv_instr_u;

endpackage

// ==== design/l0_tag_store.sv ====
/*
 * Tag and data arrays of the L0 cache with full-tag compare.
 * A line written by eviction stays invalid until its response validates it.
 * Flush only clears valid bits; tags and data are kept.
 */
`timescale 1ns/1ps

module l0_tag_store import l0_cache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_addr_t fetch_addr_i,
  input  line_tag_t   pf_tag_i,
  input  line_sel_t   evict_sel_i,
  input  line_tag_t   evict_tag_i,
  input  line_sel_t   validate_sel_i,
  input  logic        flush_i,
  input  line_t       rsp_data_i,
  output line_sel_t   hit_sel_o,
  output line_t       hit_line_o,
  output fetch_word_t fetch_data_o,
  output logic        pf_hit_o
);

  line_tag_t [LineCount-1:0] tag_q;
  line_t     [LineCount-1:0] data_q;
  line_sel_t                 valid_q;
  line_sel_t                 pf_sel;
  line_tag_t                 fetch_tag;
  logic [WordSel-1:0]        word_idx;

  assign fetch_tag = fetch_addr_i[FetchAw-1:LineAlign];
  assign word_idx  = fetch_addr_i[LineAlign-1:FetchAlign];

  // ----------------------------------------
  // arrays
  // ----------------------------------------
  // flush wins over a validate in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= (valid_q | validate_sel_i) & ~evict_sel_i;
    end
  end

  for (genvar i = 0; i < LineCount; i++) begin : gen_line
    always_ff @(posedge clk_i) begin
      if (evict_sel_i[i]) begin
        tag_q[i] <= evict_tag_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (validate_sel_i[i]) begin
        data_q[i] <= rsp_data_i;
      end
    end

    // fetch and prefetch target compare
    assign hit_sel_o[i] = valid_q[i] & (tag_q[i] == fetch_tag);
    assign pf_sel[i]    = valid_q[i] & (tag_q[i] == pf_tag_i);
  end

  assign pf_hit_o = |pf_sel;

  // ----------------------------------------
  // hit data
  // ----------------------------------------
  always_comb begin
    hit_line_o = '0;
    for (int i = 0; i < LineCount; i++) begin
      if (hit_sel_o[i]) begin
        hit_line_o |= data_q[i];
      end
    end
  end

  assign fetch_data_o = hit_line_o[word_idx];

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  // a tag is only ever written into one line, so at most one line matches
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_sel_o)
  );

  for (genvar i = 0; i < LineCount; i++) begin : gen_dup_a
    for (genvar j = i + 1; j < LineCount; j++) begin : gen_dup_b
      a_no_dup_tag : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(valid_q[i] && valid_q[j] && (tag_q[i] == tag_q[j]))
      );
    end
  end

endmodule

// ==== design/l0_refill_ctrl.sv ====
/*
 * Evictor, refill and prefetch tracking and memory port of the L0 cache.
 * At most one refill and one prefetch are outstanding at any time.
 * Responses must arrive at least one cycle after their request is accepted.
 */
`timescale 1ns/1ps

module l0_refill_ctrl import l0_cache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               fetch_valid_i,
  input  fetch_addr_t        fetch_addr_i,
  input  line_sel_t          hit_sel_i,
  input  logic               pf_req_valid_i,
  input  fetch_addr_t        pf_req_addr_i,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  input  logic [IdWidth-1:0] mem_rsp_id_i,
  output line_sel_t          evict_sel_o,
  output line_tag_t          evict_tag_o,
  output line_sel_t          validate_sel_o,
  output logic               pf_req_ready_o,
  output logic               pf_pending_o,
  output logic               mem_req_valid_o,
  output mem_req_t           mem_req_o
);

  line_tag_t fetch_tag;
  line_tag_t pf_tag;
  logic      pf_same_line;
  logic      miss, miss_q;
  logic      evict_miss, evict_pf;
  logic      pf_grant;
  logic      refill_accept;
  logic      refill_pending_q, pf_pending_q;
  line_sel_t refill_line_q, pf_line_q;
  logic [$clog2(LineCount)-1:0] rr_ptr_q, rr_ptr_d;

  assign fetch_tag = fetch_addr_i[FetchAw-1:LineAlign];
  assign pf_tag    = pf_req_addr_i[FetchAw-1:LineAlign];

  // ----------------------------------------
  // miss detection
  // ----------------------------------------
  // a fetch to the line a prefetch is bringing in just waits for it
  assign pf_same_line = (pf_req_valid_i | pf_pending_q) & (pf_tag == fetch_tag);
  assign miss = fetch_valid_i & ~(|hit_sel_i) & ~refill_pending_q & ~pf_same_line;

  assign evict_miss = miss & ~miss_q;
  // a held prefetch starts only when no refill is requested or in flight
  assign evict_pf = pf_req_valid_i & ~pf_pending_q & ~miss & ~refill_pending_q;

  // ----------------------------------------
  // round-robin evictor
  // ----------------------------------------
  always_comb begin
    evict_sel_o = '0;
    rr_ptr_d    = rr_ptr_q;
    if (evict_miss || evict_pf) begin
      evict_sel_o = line_sel_t'(1) << rr_ptr_q;
      rr_ptr_d    = rr_ptr_q + 1'b1;
      // never throw out the line the fetch is hitting
      if (evict_sel_o == hit_sel_i) begin
        evict_sel_o = line_sel_t'(1) << rr_ptr_d;
        rr_ptr_d    = rr_ptr_q + 2'd2;
      end
    end
  end

  assign evict_tag_o = evict_miss ? fetch_tag : pf_tag;

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  // a started prefetch keeps the port until accepted
  assign pf_grant        = pf_req_valid_i & (pf_pending_q | evict_pf);
  assign mem_req_valid_o = pf_grant | miss;
  assign mem_req_o.addr  = pf_grant ? pf_req_addr_i : {fetch_tag, {LineAlign{1'b0}}};
  assign mem_req_o.id    = pf_grant ? IdPrefetch : IdRefill;
  assign pf_req_ready_o  = pf_grant & mem_req_ready_i;
  assign refill_accept   = miss & ~pf_grant & mem_req_ready_i;
  assign pf_pending_o    = pf_pending_q;

  // response id picks the line to validate
  always_comb begin
    validate_sel_o = '0;
    if (mem_rsp_valid_i && (mem_rsp_id_i == IdRefill)) begin
      validate_sel_o = refill_line_q;
    end else if (mem_rsp_valid_i && (mem_rsp_id_i == IdPrefetch)) begin
      validate_sel_o = pf_line_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q           <= 1'b0;
      rr_ptr_q         <= '0;
      refill_pending_q <= 1'b0;
      pf_pending_q     <= 1'b0;
      refill_line_q    <= '0;
      pf_line_q        <= '0;
    end else begin
      miss_q   <= miss;
      rr_ptr_q <= rr_ptr_d;
      if (evict_miss) begin
        refill_line_q <= evict_sel_o;
      end
      if (evict_pf) begin
        pf_line_q    <= evict_sel_o;
        pf_pending_q <= 1'b1;
      end else if (mem_rsp_valid_i && (mem_rsp_id_i == IdPrefetch)) begin
        pf_pending_q <= 1'b0;
      end
      if (refill_accept) begin
        refill_pending_q <= 1'b1;
      end else if (mem_rsp_valid_i && (mem_rsp_id_i == IdRefill)) begin
        refill_pending_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  // lines waiting for a refill and for a prefetch are never the same line
  a_evict_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    refill_pending_q && pf_pending_q |-> !(|(refill_line_q & pf_line_q))
  );

  // a prefetch seen on the port during a refill was started before it
  a_no_pf_during_refill : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    refill_pending_q && mem_req_valid_o && (mem_req_o.id == IdPrefetch) |-> pf_pending_q
  );

  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  );

endmodule

// ==== design/l0_prefetcher.sv ====
/*
 * Instruction-aware prefetcher: predecodes the hit line from the fetch word on.
 * Backward branches and JAL are taken as predicted; JALR is not followed.
 * Holds one request until the memory port accepts it.
 */
`timescale 1ns/1ps

module l0_prefetcher import l0_cache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        prefetch_en_i,
  input  fetch_addr_t fetch_addr_i,
  input  logic        hit_any_i,
  input  line_t       hit_line_i,
  input  logic        pf_hit_i,
  input  logic        pf_pending_i,
  input  logic        pf_req_ready_i,
  output line_tag_t   pf_tag_o,
  output logic        pf_req_valid_o,
  output fetch_addr_t pf_req_addr_o
);

  rv_instr_u [FetchPkts-1:0] instr;
  rv_instr_u                 taken_instr;
  logic [FetchPkts-1:0]      is_branch, is_jal;
  logic [FetchPkts-1:0]      mask, marked;
  logic [WordSel-1:0]        word_idx, taken_idx;
  logic                      found;
  fetch_addr_t               base_addr, line_addr;
  fetch_addr_t               sb_imm, uj_imm;
  fetch_addr_t               target;
  logic                      issue;
  logic                      req_valid_q;
  fetch_addr_t               req_addr_q;

  assign word_idx  = fetch_addr_i[LineAlign-1:FetchAlign];
  assign line_addr = {fetch_addr_i[FetchAw-1:LineAlign], {LineAlign{1'b0}}};
  // words before the fetch word are not on the path
  assign mask      = {FetchPkts{1'b1}} << word_idx;

  // ----------------------------------------
  // predecode
  // ----------------------------------------
  for (genvar i = 0; i < FetchPkts; i++) begin : gen_predecode
    assign instr[i] = hit_line_i[i];
    // funct3 010 and 011 are no branch; sign of imm gives a backward branch
    assign is_branch[i] = (instr[i].b.opcode == OpcBranch) &
                          (instr[i].b.funct3[2:1] != 2'b01) &
                          instr[i].b.imm12;
    assign is_jal[i]    = (instr[i].j.opcode == OpcJal);
  end

  assign marked = mask & (is_branch | is_jal);

  // lowest marked word is the first in program order
  always_comb begin
    taken_idx = '0;
    found     = 1'b0;
    for (int i = FetchPkts - 1; i >= 0; i--) begin
      if (marked[i]) begin
        taken_idx = WordSel'(i);
        found     = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // target
  // ----------------------------------------
  assign taken_instr = instr[taken_idx];
  assign base_addr   = {fetch_addr_i[FetchAw-1:LineAlign], taken_idx, {FetchAlign{1'b0}}};

  assign sb_imm = {{19{taken_instr.b.imm12}}, taken_instr.b.imm12, taken_instr.b.imm11,
                   taken_instr.b.imm10_5, taken_instr.b.imm4_1, 1'b0};
  assign uj_imm = {{11{taken_instr.j.imm20}}, taken_instr.j.imm20, taken_instr.j.imm19_12,
                   taken_instr.j.imm11, taken_instr.j.imm10_1, 1'b0};

  always_comb begin
    if (!found) begin
      target = line_addr + (fetch_addr_t'(1) << LineAlign);
    end else if (is_jal[taken_idx]) begin
      target = base_addr + uj_imm;
    end else begin
      target = base_addr + sb_imm;
    end
  end

  assign pf_tag_o = target[FetchAw-1:LineAlign];

  // ----------------------------------------
  // held request
  // ----------------------------------------
  assign issue = prefetch_en_i & hit_any_i & ~pf_hit_i & ~pf_pending_i & ~req_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (issue) begin
      req_valid_q <= 1'b1;
    end else if (pf_req_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_addr_q <= {pf_tag_o, {LineAlign{1'b0}}};
    end
  end

  assign pf_req_valid_o = req_valid_q;
  assign pf_req_addr_o  = req_addr_q;

endmodule

// ==== design/l0_cache_top.sv ====
/*
 * L0 instruction cache top: four fully associative lines, one fetch port.
 * The requester must hold fetch valid and address until ready.
 */
`timescale 1ns/1ps

module l0_cache_top import l0_cache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        prefetch_en_i,
  input  logic        fetch_valid_i,
  input  fetch_addr_t fetch_addr_i,
  output logic        fetch_ready_o,
  output fetch_word_t fetch_data_o,
  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_req_ready_i,
  input  logic        mem_rsp_valid_i,
  input  mem_rsp_t    mem_rsp_i
);

  line_sel_t   hit_sel, evict_sel, validate_sel;
  line_tag_t   evict_tag, pf_tag;
  line_t       hit_line;
  logic        hit_any, pf_hit;
  logic        pf_req_valid, pf_req_ready, pf_pending;
  fetch_addr_t pf_req_addr;

  assign fetch_ready_o = |hit_sel;
  // only a real fetch may trigger a prefetch
  assign hit_any = fetch_valid_i & fetch_ready_o;

  l0_tag_store l0_tag_store_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_addr_i   (fetch_addr_i),
    .pf_tag_i       (pf_tag),
    .evict_sel_i    (evict_sel),
    .evict_tag_i    (evict_tag),
    .validate_sel_i (validate_sel),
    .flush_i        (flush_i),
    .rsp_data_i     (mem_rsp_i.data),
    .hit_sel_o      (hit_sel),
    .hit_line_o     (hit_line),
    .fetch_data_o   (fetch_data_o),
    .pf_hit_o       (pf_hit)
  );

  l0_refill_ctrl l0_refill_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .hit_sel_i       (hit_sel),
    .pf_req_valid_i  (pf_req_valid),
    .pf_req_addr_i   (pf_req_addr),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_id_i    (mem_rsp_i.id),
    .evict_sel_o     (evict_sel),
    .evict_tag_o     (evict_tag),
    .validate_sel_o  (validate_sel),
    .pf_req_ready_o  (pf_req_ready),
    .pf_pending_o    (pf_pending),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o)
  );

  l0_prefetcher l0_prefetcher_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .prefetch_en_i  (prefetch_en_i),
    .fetch_addr_i   (fetch_addr_i),
    .hit_any_i      (hit_any),
    .hit_line_i     (hit_line),
    .pf_hit_i       (pf_hit),
    .pf_pending_i   (pf_pending),
    .pf_req_ready_i (pf_req_ready),
    .pf_tag_o       (pf_tag),
    .pf_req_valid_o (pf_req_valid),
    .pf_req_addr_o  (pf_req_addr)
  );

  // fetch port protocol
  a_fetch_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_o |=> fetch_valid_i && $stable(fetch_addr_i)
  );

endmodule

// ==== dv/l0_cache_tb.sv ====
/*
 * Testbench for the L0 cache, stimulus and expected values from dv/l0_cache_trace.txt.
 * The memory model looks requests up in the M records and answers after 0 to 3 cycles.
 * The memory port is drained between fetch records, so each record is checked alone.
 */
`timescale 1ns/1ps

module l0_cache_tb import l0_cache_pkg::*; ();

  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned DriveDelay  = 1;
  localparam int unsigned RecWords    = 8;
  localparam int unsigned TraceWords  = 512;
  localparam int unsigned IdleCycles  = 3;
  localparam int unsigned WdogCycles  = 200;

  typedef struct packed {
    fetch_addr_t addr;
    fetch_word_t word;
    logic        pf_valid;
    fetch_addr_t pf_addr;
    logic        flush;
    logic        pfen;
    logic        refill;
  } fetch_rec_t;

  logic        clk_i, rst_ni, flush_i, prefetch_en_i, fetch_valid_i;
  fetch_addr_t fetch_addr_i;
  logic        fetch_ready_o;
  fetch_word_t fetch_data_o;
  logic        mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i;
  mem_req_t    mem_req_o;
  mem_rsp_t    mem_rsp_i;

  logic [31:0] trace_mem [TraceWords];
  fetch_addr_t line_addrs [$];
  line_t       line_data [$];
  fetch_rec_t  fetch_recs [$];
  logic        trace_done = 1'b0;
  mem_req_t    pending_q [$];
  mem_req_t    seen_q [$];
  logic        rsp_busy;
  logic [15:0] lfsr_q;
  int unsigned word_errs = 0;
  int unsigned req_errs = 0;
  int unsigned other_errs = 0;

  l0_cache_top l0_cache_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .prefetch_en_i   (prefetch_en_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_data_o    (fetch_data_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic rand_bit();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (out_bit) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out_bit;
  endfunction

  task automatic load_trace();
    int unsigned k;
    fetch_rec_t  rec;
    $readmemh("dv/l0_cache_trace.txt", trace_mem);
    k = 0;
    while (k + RecWords <= TraceWords &&
           (trace_mem[k] === 32'd1 || trace_mem[k] === 32'd2)) begin
      if (trace_mem[k] === 32'd1) begin
        line_addrs.push_back(trace_mem[k+1]);
        line_data.push_back({trace_mem[k+5], trace_mem[k+4], trace_mem[k+3], trace_mem[k+2]});
      end else begin
        rec.addr     = trace_mem[k+1];
        rec.word     = trace_mem[k+2];
        rec.pf_valid = trace_mem[k+3][0];
        rec.pf_addr  = trace_mem[k+4];
        rec.flush    = trace_mem[k+5][0];
        rec.pfen     = trace_mem[k+6][0];
        rec.refill   = trace_mem[k+7][0];
        fetch_recs.push_back(rec);
      end
      k += RecWords;
    end
    trace_done = 1'b1;
  endtask

  task automatic lookup_line(input fetch_addr_t addr, output line_t data);
    logic found;
    found = 1'b0;
    data  = '0;
    foreach (line_addrs[i]) begin
      if (line_addrs[i] == addr) begin
        data  = line_data[i];
        found = 1'b1;
      end
    end
    if (!found) begin
      $display("memory request to line %h has no M record in the trace", addr);
      other_errs++;
    end
  endtask

  task automatic check_word(input fetch_word_t got, input fetch_word_t exp);
    if (got !== exp) begin
      $display("Error: fetch_data_o got %h expected %h at %0t", got, exp, $time);
      word_errs++;
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("Error: mem_req_o got addr %h id %h expected addr %h id %h",
               got.addr, got.id, exp.addr, exp.id);
      req_errs++;
    end
  endtask

  // quiet means no request, no response and nothing queued in the model
  task automatic wait_idle();
    int unsigned quiet;
    quiet = 0;
    while (quiet < IdleCycles) begin
      @(negedge clk_i);
      if (!mem_req_valid_o && !mem_rsp_valid_i && !rsp_busy && pending_q.size() == 0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic run_fetch(input fetch_rec_t rec);
    int unsigned cycles;
    int unsigned n_refill;
    int unsigned n_pf;
    mem_req_t    exp_req;
    @(posedge clk_i);
    #DriveDelay;
    prefetch_en_i = rec.pfen;
    if (rec.flush) begin
      flush_i = 1'b1;
      @(posedge clk_i);
      #DriveDelay;
      flush_i = 1'b0;
    end
    seen_q.delete();
    fetch_valid_i = 1'b1;
    fetch_addr_i  = rec.addr;
    cycles = 0;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      cycles++;
      @(negedge clk_i);
    end
    check_word(fetch_data_o, rec.word);
    if (!rec.refill && cycles != 0) begin
      $display("fetch at %h should hit but waited %0d cycles", rec.addr, cycles);
      other_errs++;
    end
    @(posedge clk_i);
    #DriveDelay;
    fetch_valid_i = 1'b0;
    // a prefetch starts one cycle after the hit, so drain it too
    wait_idle();
    n_refill = 0;
    n_pf     = 0;
    foreach (seen_q[i]) begin
      if (seen_q[i].id == IdRefill) begin
        n_refill++;
        exp_req.addr = {rec.addr[FetchAw-1:LineAlign], {LineAlign{1'b0}}};
        exp_req.id   = IdRefill;
        check_req(seen_q[i], exp_req);
      end else if (seen_q[i].id == IdPrefetch) begin
        n_pf++;
        exp_req.addr = rec.pf_addr;
        exp_req.id   = IdPrefetch;
        check_req(seen_q[i], exp_req);
      end else begin
        $display("memory request with unknown id %h", seen_q[i].id);
        other_errs++;
      end
    end
    if (n_refill != (rec.refill ? 1 : 0)) begin
      $display("fetch at %h made %0d refill requests instead of %0d",
               rec.addr, n_refill, rec.refill);
      other_errs++;
    end
    if (n_pf != (rec.pf_valid ? 1 : 0)) begin
      $display("fetch at %h made %0d prefetch requests instead of %0d",
               rec.addr, n_pf, rec.pf_valid);
      other_errs++;
    end
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin : memory_model
    mem_req_t    rsp_req;
    logic [1:0]  rsp_wait;
    line_t       data;
    logic [1:0]  pick;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    rsp_busy        = 1'b0;
    rsp_wait        = '0;
    lfsr_q          = 16'd43;
    wait (rst_ni === 1'b1);
    forever begin
      // transfer happens at the coming rising edge
      @(negedge clk_i);
      if (mem_req_valid_o && mem_req_ready_i) begin
        pending_q.push_back(mem_req_o);
        seen_q.push_back(mem_req_o);
      end
      @(posedge clk_i);
      #DriveDelay;
      mem_rsp_valid_i = 1'b0;
      if (rsp_busy) begin
        if (rsp_wait == 0) begin
          lookup_line(rsp_req.addr, data);
          mem_rsp_valid_i = 1'b1;
          mem_rsp_i.data  = data;
          mem_rsp_i.id    = rsp_req.id;
          rsp_busy        = 1'b0;
        end else begin
          rsp_wait--;
        end
      end else if (pending_q.size() != 0) begin
        rsp_req     = pending_q.pop_front();
        rsp_wait[1] = rand_bit();
        rsp_wait[0] = rand_bit();
        rsp_busy    = 1'b1;
      end
      // ready is low about one cycle in four
      pick[1] = rand_bit();
      pick[0] = rand_bit();
      mem_req_ready_i = |pick;
    end
  end

  // ----------------------------------------
  // stimulus and result
  // ----------------------------------------
  initial begin : stimulus
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    prefetch_en_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    load_trace();
    if (fetch_recs.size() == 0) begin
      $display("trace file holds no fetch records");
      other_errs++;
    end
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    foreach (fetch_recs[k]) begin
      run_fetch(fetch_recs[k]);
    end
    $display("errors: word %0d, request %0d, other %0d", word_errs, req_errs, other_errs);
    if (word_errs + req_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (trace_done);
    repeat (fetch_recs.size() * WdogCycles) @(posedge clk_i);
    $display("watchdog expired, the run did not finish in %0d cycles",
             fetch_recs.size() * WdogCycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
design/l0_cache_pkg.sv
design/l0_tag_store.sv
design/l0_refill_ctrl.sv
design/l0_prefetcher.sv
design/l0_cache_top.sv
dv/l0_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l0_cache

sources:
  - design/l0_cache_pkg.sv
  - design/l0_tag_store.sv
  - design/l0_refill_ctrl.sv
  - design/l0_prefetcher.sv
  - design/l0_cache_top.sv
  - target: test
    files:
      - dv/l0_cache_tb.sv

// ==== dv/l0_cache_trace.txt ====
// kind 1 = M line: line_addr word0 word1 word2 word3 0 0
// kind 2 = F fetch: fetch_addr exp_word pf_valid pf_addr flush prefetch_en refill
1 00001000 10000093 10100093 10200093 10300093 0 0
1 00002000 20000093 20100093 20200093 20300093 0 0
1 00003000 30000093 30100093 30200093 30300093 0 0
1 00003010 31000093 31100093 31200093 31300093 0 0
1 00003020 32000093 32100093 32200093 32300093 0 0
1 00004000 40000093 40100093 40200093 40300093 0 0
1 00005000 50000093 50100093 50200093 50300093 0 0
1 00005FC0 5F000093 5F100093 5F200093 5F300093 0 0
1 00006000 60000093 60100093 FC0000E3 60300093 0 0
1 00006010 61000093 61100093 61200093 61300093 0 0
1 00006FE0 6F000093 6F100093 6F200093 6F300093 0 0
1 00007000 04001063 70100093 1000006F FE0040E3 0 0
1 00007100 71000093 71100093 71200093 71300093 0 0
1 00008000 80000093 02000063 80200093 80300093 0 0
1 00008010 81000093 81100093 81200093 81300093 0 0
// miss, hit, then five lines round-robin and the first one again
2 00001004 10100093 0 00000000 0 0 1
2 00001008 10200093 0 00000000 0 0 0
2 00002000 20000093 0 00000000 0 0 1
2 00003000 30000093 0 00000000 0 0 1
2 00004000 40000093 0 00000000 0 0 1
2 00005000 50000093 0 00000000 0 0 1
2 0000100C 10300093 0 00000000 0 0 1
2 00003004 30100093 0 00000000 1 0 1
// prefetch on: sequential, backward branch, masked branch, jal, forward branch
2 00003008 30200093 1 00003010 0 1 0
2 00003010 31000093 1 00003020 0 1 0
2 00006004 60100093 1 00005FC0 0 1 1
2 0000600C 60300093 1 00006010 0 1 0
2 00007000 04001063 1 00007100 0 1 1
2 00008004 02000063 1 00008010 0 1 1
2 00008008 80200093 0 00000000 0 1 0
2 0000700C FE0040E3 1 00006FE0 0 1 0
2 00007008 1000006F 1 00007100 0 1 0
2 00007104 71100093 0 00000000 0 0 0
2 00008000 80000093 0 00000000 0 0 1
